// File: design/tinker_pkg.sv
package tinker_pkg;

    localparam int xlen = 64; // data path width
    localparam int ilen = 32; // instruction width

    typedef logic [4:0] reg_addr_t;

    // tinker opcode points, [31:27] of the instruction
    typedef enum logic [4:0] {
        op_and    = 5'h00,
        op_or     = 5'h01,
        op_xor    = 5'h02,
        op_not    = 5'h03,
        op_shftr  = 5'h04,
        op_shftri = 5'h05,
        op_shftl  = 5'h06,
        op_shftli = 5'h07,
        op_br     = 5'h08, // pc = rd
        op_brr_rd = 5'h09, // pc += rd
        op_brr_l  = 5'h0a, // pc += sext(L)
        op_brnz   = 5'h0b,
        op_brgt   = 5'h0e,
        op_halt   = 5'h0f,
        op_load   = 5'h10, // mov rd,(rs)(L)
        op_mov_rr = 5'h11,
        op_mov_rl = 5'h12,
        op_store  = 5'h13, // mov (rd)(L),rs
        op_add    = 5'h18,
        op_addi   = 5'h19,
        op_sub    = 5'h1a,
        op_subi   = 5'h1b
    } opcode_t;

    localparam logic [ilen-1:0] nop_word = 32'h8800_0000; // mov r0,r0

    typedef enum logic [1:0] {
        from_regfile = 2'd0,
        from_exmem   = 2'd1,
        from_memwb   = 2'd2
    } fwd_sel_t;

    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic mem_to_reg; // wb picks load data
        logic halt;
    } ctrl_t;

    typedef struct packed {
        ctrl_t            ctrl;
        opcode_t          opcode;
        reg_addr_t        rd;
        reg_addr_t        rs;
        reg_addr_t        rt;
        logic [11:0]      lit;
        logic [31:0]      pc;
        logic [xlen-1:0]  rd_val;
        logic [xlen-1:0]  rs_val;
        logic [xlen-1:0]  rt_val;
    } idex_t;

    typedef struct packed {
        ctrl_t            ctrl;
        logic [xlen-1:0]  alu_result; // also the mem address
        logic [xlen-1:0]  store_data;
        reg_addr_t        dest;
    } exmem_t;

    typedef struct packed {
        ctrl_t            ctrl;
        logic [xlen-1:0]  load_data;
        logic [xlen-1:0]  alu_result;
        reg_addr_t        dest;
    } memwb_t;

    typedef struct packed {
        logic             we;
        reg_addr_t        dest;
        logic [xlen-1:0]  data;
    } wb_t;

    typedef struct packed {
        logic             we;
        logic [12:0]      addr; // double word index
        logic [xlen-1:0]  data;
    } prog_load_t;

    typedef struct packed {
        logic             valid;
        logic [31:0]      addr;
        logic [xlen-1:0]  data;
    } store_obs_t;

endpackage

// File: design/fetch_unit.sv
module fetch_unit #(
    parameter logic [31:0] pc_reset_addr = 32'h0000_2000
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [tinker_pkg::ilen-1:0] instr,         // word at pc
    input  logic                        stall,         // load-use hold
    input  logic                        branch_taken,
    input  logic [31:0]                 branch_target,
    input  logic                        halt_seen,
    output logic [31:0]                 pc,
    output logic [tinker_pkg::ilen-1:0] ifid_instr,
    output logic [31:0]                 ifid_pc
);
    logic halted; // sticky stop after halt decode

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc         <= pc_reset_addr;
            ifid_instr <= tinker_pkg::nop_word;
            ifid_pc    <= '0;
            halted     <= 1'b0;
        end else begin
            if (halt_seen)
                halted <= 1'b1;
            if (branch_taken) begin
                pc         <= branch_target;
                ifid_instr <= tinker_pkg::nop_word; // squash wrong-path word
                ifid_pc    <= '0;
            end else if (halted || halt_seen) begin
                ifid_instr <= tinker_pkg::nop_word; // drain, pc frozen
            end else if (!stall) begin
                pc         <= pc + 32'd4;
                ifid_instr <= instr;
                ifid_pc    <= pc;
            end
        end
    end

    // word aligned fetch, including branch targets
    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// File: design/decode_unit.sv
module decode_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [tinker_pkg::ilen-1:0] ifid_instr,
    input  logic [31:0]                 ifid_pc,
    output tinker_pkg::reg_addr_t       rf_addr_rd,
    output tinker_pkg::reg_addr_t       rf_addr_rs,
    output tinker_pkg::reg_addr_t       rf_addr_rt,
    input  logic [tinker_pkg::xlen-1:0] rf_rd_val,
    input  logic [tinker_pkg::xlen-1:0] rf_rs_val,
    input  logic [tinker_pkg::xlen-1:0] rf_rt_val,
    output logic                        stall,
    output logic                        branch_taken,
    output logic [31:0]                 branch_target,
    output logic                        halt_seen,
    output tinker_pkg::idex_t           idex
);
    tinker_pkg::opcode_t op;
    logic [11:0]         lit;
    tinker_pkg::ctrl_t   ctrl;
    logic                take_raw; // branch decision before stall gating

    // field split
    assign op         = tinker_pkg::opcode_t'(ifid_instr[31:27]);
    assign rf_addr_rd = ifid_instr[26:22];
    assign rf_addr_rs = ifid_instr[21:17];
    assign rf_addr_rt = ifid_instr[16:12];
    assign lit        = ifid_instr[11:0];

    always_comb begin
        ctrl = '0;
        case (op)
            tinker_pkg::op_add, tinker_pkg::op_addi, tinker_pkg::op_sub, tinker_pkg::op_subi,
            tinker_pkg::op_and, tinker_pkg::op_or, tinker_pkg::op_xor, tinker_pkg::op_not,
            tinker_pkg::op_shftr, tinker_pkg::op_shftri, tinker_pkg::op_shftl,
            tinker_pkg::op_shftli, tinker_pkg::op_mov_rr, tinker_pkg::op_mov_rl:
                ctrl.reg_write = 1'b1;
            tinker_pkg::op_load: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            tinker_pkg::op_store: ctrl.mem_write = 1'b1;
            tinker_pkg::op_halt:  ctrl.halt      = 1'b1;
            default: ; // branches and unknown codes carry no control
        endcase
    end

    // early branch resolve, regfile values only
    always_comb begin
        take_raw      = 1'b0;
        branch_target = ifid_pc + 32'd4;
        case (op)
            tinker_pkg::op_br: begin
                take_raw      = 1'b1;
                branch_target = rf_rd_val[31:0];
            end
            tinker_pkg::op_brr_rd: begin
                take_raw      = 1'b1;
                branch_target = ifid_pc + rf_rd_val[31:0];
            end
            tinker_pkg::op_brr_l: begin
                take_raw      = 1'b1;
                branch_target = ifid_pc + {{20{lit[11]}}, lit};
            end
            tinker_pkg::op_brnz: begin
                take_raw      = (rf_rs_val != '0);
                branch_target = rf_rd_val[31:0];
            end
            tinker_pkg::op_brgt: begin
                take_raw      = ($signed(rf_rs_val) > $signed(rf_rt_val));
                branch_target = rf_rd_val[31:0];
            end
            default: ;
        endcase
    end

    // load in ID/EX feeding any field of this instruction
    assign stall = idex.ctrl.mem_read &&
                   ((idex.rd == rf_addr_rd) || (idex.rd == rf_addr_rs) ||
                    (idex.rd == rf_addr_rt));

    assign branch_taken = take_raw && !stall;  // retried after the hold
    assign halt_seen    = ctrl.halt && !stall;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idex <= '0;
        end else if (stall) begin
            idex <= '0; // bubble
        end else begin
            idex <= '{ctrl: ctrl, opcode: op, rd: rf_addr_rd, rs: rf_addr_rs,
                      rt: rf_addr_rt, lit: lit, pc: ifid_pc, rd_val: rf_rd_val,
                      rs_val: rf_rs_val, rt_val: rf_rt_val};
        end
    end

    // a taken branch never waits on a load still in ID/EX
    no_branch_on_stall: assert property (
        @(posedge clk) disable iff (reset) !(take_raw && stall));

endmodule

// File: design/register_file.sv
module register_file (
    input  logic                        clk,
    input  logic                        reset,
    input  tinker_pkg::wb_t             wb,
    input  tinker_pkg::reg_addr_t       addr_rd,
    input  tinker_pkg::reg_addr_t       addr_rs,
    input  tinker_pkg::reg_addr_t       addr_rt,
    output logic [tinker_pkg::xlen-1:0] rd_val,
    output logic [tinker_pkg::xlen-1:0] rs_val,
    output logic [tinker_pkg::xlen-1:0] rt_val
);
    logic [tinker_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wb.we) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // same-cycle write seen by the read
    function automatic logic [tinker_pkg::xlen-1:0] rd_port(input tinker_pkg::reg_addr_t a);
        return (wb.we && wb.dest == a) ? wb.data : regs[a];
    endfunction

    always_comb begin
        rd_val = rd_port(addr_rd);
        rs_val = rd_port(addr_rs);
        rt_val = rd_port(addr_rt);
    end

endmodule

// File: design/execute_unit.sv
module execute_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  tinker_pkg::idex_t     idex,
    input  tinker_pkg::reg_addr_t memwb_dest,
    input  logic                  memwb_write,
    input  tinker_pkg::wb_t       wb,          // value for MEM/WB forwarding
    output tinker_pkg::exmem_t    exmem
);
    tinker_pkg::fwd_sel_t        sel_rd, sel_rs, sel_rt;
    logic [tinker_pkg::xlen-1:0] rd_f, rs_f, rt_f; // forwarded operands
    logic [tinker_pkg::xlen-1:0] lit_z;            // zero-extended L
    logic [tinker_pkg::xlen-1:0] lit_s;            // sign-extended L
    logic [tinker_pkg::xlen-1:0] alu_out;

    // newest producer wins
    function automatic tinker_pkg::fwd_sel_t pick(input tinker_pkg::reg_addr_t r);
        if (exmem.ctrl.reg_write && exmem.dest == r)
            return tinker_pkg::from_exmem;
        if (memwb_write && memwb_dest == r)
            return tinker_pkg::from_memwb;
        return tinker_pkg::from_regfile;
    endfunction

    function automatic logic [tinker_pkg::xlen-1:0] operand(
        input tinker_pkg::fwd_sel_t sel, input logic [tinker_pkg::xlen-1:0] rf_val);
        case (sel)
            tinker_pkg::from_exmem: return exmem.alu_result;
            tinker_pkg::from_memwb: return wb.data;
            default:                return rf_val;
        endcase
    endfunction

    always_comb begin
        sel_rd = pick(idex.rd);
        sel_rs = pick(idex.rs);
        sel_rt = pick(idex.rt);
        rd_f   = operand(sel_rd, idex.rd_val);
        rs_f   = operand(sel_rs, idex.rs_val);
        rt_f   = operand(sel_rt, idex.rt_val);
    end

    assign lit_z  = {52'd0, idex.lit};
    assign lit_s  = {{52{idex.lit[11]}}, idex.lit};

    always_comb begin
        case (idex.opcode)
            tinker_pkg::op_add:    alu_out = rs_f + rt_f;
            tinker_pkg::op_addi:   alu_out = rd_f + lit_z;
            tinker_pkg::op_sub:    alu_out = rs_f - rt_f;
            tinker_pkg::op_subi:   alu_out = rd_f - lit_z;
            tinker_pkg::op_and:    alu_out = rs_f & rt_f;
            tinker_pkg::op_or:     alu_out = rs_f | rt_f;
            tinker_pkg::op_xor:    alu_out = rs_f ^ rt_f;
            tinker_pkg::op_not:    alu_out = ~rs_f;            // rt ignored
            tinker_pkg::op_shftr:  alu_out = rs_f >> rt_f;
            tinker_pkg::op_shftri: alu_out = rd_f >> idex.lit;
            tinker_pkg::op_shftl:  alu_out = rs_f << rt_f;
            tinker_pkg::op_shftli: alu_out = rd_f << idex.lit;
            tinker_pkg::op_mov_rr: alu_out = rs_f;
            tinker_pkg::op_mov_rl: alu_out = {rd_f[63:12], idex.lit}; // low 12 only
            tinker_pkg::op_load:   alu_out = rs_f + lit_s;     // base rs
            tinker_pkg::op_store:  alu_out = rd_f + lit_s;     // base rd
            default:               alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            exmem <= '0;
        else
            exmem <= '{ctrl: idex.ctrl, alu_result: alu_out, store_data: rs_f,
                       dest: idex.rd};
    end

endmodule

// File: design/unified_memory.sv
module unified_memory #(
    parameter int mem_bytes = 65536
) (
    input  logic                        clk,
    input  logic [31:0]                 fetch_addr,
    output logic [tinker_pkg::ilen-1:0] instr,
    input  tinker_pkg::exmem_t          exmem,       // MEM stage access
    output logic [tinker_pkg::xlen-1:0] load_data,
    input  tinker_pkg::prog_load_t      prog_load,
    output tinker_pkg::store_obs_t      store_obs
);
    localparam int aw = $clog2(mem_bytes);

    logic [7:0]    mem [mem_bytes];
    logic [aw-1:0] f_a;  // fetch byte address
    logic [aw-1:0] d_a;  // load/store byte address
    logic [aw-1:0] pl_a; // program load byte address

    assign f_a  = fetch_addr[aw-1:0];
    assign d_a  = exmem.alu_result[aw-1:0];
    assign pl_a = aw'({prog_load.addr, 3'b000});

    // little-endian reads, lowest byte at the address
    always_comb begin
        for (int k = 0; k < 4; k++)
            instr[8*k +: 8] = mem[f_a + aw'(k)];
        for (int k = 0; k < 8; k++)
            load_data[8*k +: 8] = mem[d_a + aw'(k)];
    end

    always_ff @(posedge clk) begin
        if (prog_load.we) begin
            for (int k = 0; k < 8; k++)
                mem[pl_a + aw'(k)] <= prog_load.data[8*k +: 8];
        end else if (exmem.ctrl.mem_write) begin
            for (int k = 0; k < 8; k++)
                mem[d_a + aw'(k)] <= exmem.store_data[8*k +: 8];
        end
    end

    assign store_obs.valid = exmem.ctrl.mem_write;
    assign store_obs.addr  = exmem.alu_result[31:0];
    assign store_obs.data  = exmem.store_data;

    store_in_range: assert property (@(posedge clk)
        exmem.ctrl.mem_write |-> (exmem.alu_result + 64'd8 <= 64'(mem_bytes)));

    // loading only runs under reset, when the pipeline is empty
    no_load_store_overlap: assert property (@(posedge clk)
        !(prog_load.we && exmem.ctrl.mem_write));

endmodule

// File: design/writeback_unit.sv
module writeback_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  tinker_pkg::exmem_t          exmem,
    input  logic [tinker_pkg::xlen-1:0] load_data,  // combinational MEM read
    output tinker_pkg::reg_addr_t       memwb_dest,
    output logic                        memwb_write,
    output tinker_pkg::wb_t             wb,
    output logic                        hlt
);
    tinker_pkg::memwb_t memwb;
    logic               hlt_hold; // keeps hlt up after the halt leaves

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            memwb    <= '0;
            hlt_hold <= 1'b0;
        end else begin
            memwb <= '{ctrl: exmem.ctrl, load_data: load_data,
                       alu_result: exmem.alu_result, dest: exmem.dest};
            if (memwb.ctrl.halt)
                hlt_hold <= 1'b1;
        end
    end

    assign memwb_dest  = memwb.dest;
    assign memwb_write = memwb.ctrl.reg_write;
    assign wb.we       = memwb.ctrl.reg_write;
    assign wb.dest     = memwb.dest;
    assign wb.data     = memwb.ctrl.mem_to_reg ? memwb.load_data : memwb.alu_result;
    assign hlt         = memwb.ctrl.halt || hlt_hold;

endmodule

// File: design/tinker_core.sv
module tinker_core #(
    parameter logic [31:0] pc_reset_addr = 32'h0000_2000,
    parameter int          mem_bytes     = 65536
) (
    input  logic                   clk,
    input  logic                   reset,
    input  tinker_pkg::prog_load_t prog_load,
    output tinker_pkg::store_obs_t store_obs,
    output logic                   hlt
);
    // fetch side
    logic [31:0]                 pc;
    logic [tinker_pkg::ilen-1:0] instr;
    logic [tinker_pkg::ilen-1:0] ifid_instr;
    logic [31:0]                 ifid_pc;

    // decode feedback to fetch
    logic        stall;
    logic        branch_taken;
    logic [31:0] branch_target;
    logic        halt_seen;

    // register file read ports
    tinker_pkg::reg_addr_t       rf_addr_rd;
    tinker_pkg::reg_addr_t       rf_addr_rs;
    tinker_pkg::reg_addr_t       rf_addr_rt;
    logic [tinker_pkg::xlen-1:0] rf_rd_val;
    logic [tinker_pkg::xlen-1:0] rf_rs_val;
    logic [tinker_pkg::xlen-1:0] rf_rt_val;

    // later stages
    tinker_pkg::idex_t           idex;
    tinker_pkg::exmem_t          exmem;
    logic [tinker_pkg::xlen-1:0] load_data;
    tinker_pkg::reg_addr_t       memwb_dest;
    logic                        memwb_write;
    tinker_pkg::wb_t             wb;

    fetch_unit #(.pc_reset_addr(pc_reset_addr)) u_fetch (
        .clk(clk), .reset(reset),
        .instr(instr),
        .stall(stall), .branch_taken(branch_taken),
        .branch_target(branch_target), .halt_seen(halt_seen),
        .pc(pc), .ifid_instr(ifid_instr), .ifid_pc(ifid_pc)
    );

    decode_unit u_decode (
        .clk(clk), .reset(reset),
        .ifid_instr(ifid_instr), .ifid_pc(ifid_pc),
        .rf_addr_rd(rf_addr_rd), .rf_addr_rs(rf_addr_rs), .rf_addr_rt(rf_addr_rt),
        .rf_rd_val(rf_rd_val), .rf_rs_val(rf_rs_val), .rf_rt_val(rf_rt_val),
        .stall(stall), .branch_taken(branch_taken),
        .branch_target(branch_target), .halt_seen(halt_seen),
        .idex(idex)
    );

    register_file u_regs (
        .clk(clk), .reset(reset), .wb(wb),
        .addr_rd(rf_addr_rd), .addr_rs(rf_addr_rs), .addr_rt(rf_addr_rt),
        .rd_val(rf_rd_val), .rs_val(rf_rs_val), .rt_val(rf_rt_val)
    );

    execute_unit u_execute (
        .clk(clk), .reset(reset), .idex(idex),
        .memwb_dest(memwb_dest), .memwb_write(memwb_write),
        .wb(wb), .exmem(exmem)
    );

    unified_memory #(.mem_bytes(mem_bytes)) u_mem (
        .clk(clk), .fetch_addr(pc), .instr(instr),
        .exmem(exmem), .load_data(load_data),
        .prog_load(prog_load), .store_obs(store_obs)
    );

    writeback_unit u_writeback (
        .clk(clk), .reset(reset), .exmem(exmem), .load_data(load_data),
        .memwb_dest(memwb_dest), .memwb_write(memwb_write),
        .wb(wb), .hlt(hlt)
    );

endmodule

// File: sim/tb_tinker_core.sv
module tb_tinker_core;

    localparam int max_load_records = 16; // one record per reset cycle
    localparam int halt_timeout     = 2000;
    localparam int post_halt_cycles = 20;

    logic                   clk;
    logic                   reset;
    tinker_pkg::prog_load_t prog_load;
    tinker_pkg::store_obs_t store_obs;
    logic                   hlt;

    // program records from the data file
    logic [31:0] load_addr_q [$];
    logic [63:0] load_data_q [$];

    // expected stores, oldest first
    int          exp_test_q [$];
    logic [31:0] exp_addr_q [$];
    logic [63:0] exp_data_q [$];

    string store_name; // label for the store under check

    tinker_core DUT (
        .clk(clk),
        .reset(reset),
        .prog_load(prog_load),
        .store_obs(store_obs),
        .hlt(hlt)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk; // period 8

    // compares one value with its expected value
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "run stopped");
    endtask

    // parse P and S records and skip # lines
    task automatic read_records();
        int          fd;
        int          n;
        int          test_num;
        logic [31:0] addr;
        logic [63:0] data;
        string       line;
        fd = $fopen("sim/program_input.mem", "r");
        if (fd == 0)
            stop_run("cannot open sim/program_input.mem");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0) begin
                if (line.getc(0) == "P") begin
                    if ($sscanf(line, "P %h %h", addr, data) == 2) begin
                        load_addr_q.push_back(addr);
                        load_data_q.push_back(data);
                    end
                end else if (line.getc(0) == "S") begin
                    if ($sscanf(line, "S %d %h %h", test_num, addr, data) == 3) begin
                        exp_test_q.push_back(test_num);
                        exp_addr_q.push_back(addr);
                        exp_data_q.push_back(data);
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    // store monitor samples at the falling edge
    always @(negedge clk) begin
        if (!reset && store_obs.valid) begin
            if (hlt)
                stop_run($sformatf("a store to %h appeared after halt", store_obs.addr));
            if (exp_addr_q.size() == 0)
                stop_run($sformatf("unexpected store to %h", store_obs.addr));
            store_name = $sformatf("test %0d", exp_test_q[0]);
            check_value({store_name, " address"}, {32'd0, exp_addr_q[0]},
                        {32'd0, store_obs.addr});
            check_value({store_name, " data"}, exp_data_q[0], store_obs.data);
            void'(exp_test_q.pop_front());
            void'(exp_addr_q.pop_front());
            void'(exp_data_q.pop_front());
        end
    end

    initial begin
        int cycles;
        reset     = 1'b1;
        prog_load = '0;
        read_records();
        if (load_addr_q.size() > max_load_records)
            stop_run("too many program records for the reset window");

        // program loads one double word per reset cycle
        for (int i = 0; i < max_load_records; i++) begin
            @(posedge clk);
            if (i < load_addr_q.size())
                prog_load <= '{we: 1'b1, addr: load_addr_q[i][12:0], data: load_data_q[i]};
            else
                prog_load <= '0;
        end
        @(posedge clk);
        reset     <= 1'b0;
        prog_load <= '0;

        // run until halt reaches writeback
        cycles = 0;
        while (!hlt && cycles < halt_timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (!hlt)
            stop_run("timeout: hlt never went high");

        // hlt must stay up while the store monitor watches for late stores
        for (int i = 0; i < post_halt_cycles; i++) begin
            @(negedge clk);
            check_value("hlt held high", 64'd1, {63'd0, hlt});
        end

        if (exp_addr_q.size() != 0) begin
            $display("%0d expected stores never appeared", exp_addr_q.size());
            $display("Test failures found");
            $fatal(1, "missing stores");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// File: flist.f
design/tinker_pkg.sv
design/fetch_unit.sv
design/decode_unit.sv
design/register_file.sv
design/execute_unit.sv
design/unified_memory.sv
design/writeback_unit.sv
design/tinker_core.sv
sim/tb_tinker_core.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, then run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module tb_tinker_core -o tb_sim &&
./obj_dir/tb_sim || exit 1

// File: sim/program_input.mem
# P dword_index data : program double word, high word is the instruction at addr+4
# S test address data : expected store in order of appearance
P 400 C0C21000_90400123
P 401 11464000_D1061000
P 402 09CC4000_018A3000
P 403 98100100_1A0E0000
P 404 3B000004_93000200
P 405 8B580000_C84000FF
P 406 D8400020_8B980000
P 407 9300006C_28400001
P 408 9380007C_93400074
P 409 82800108_981A0108
P 40A 98160110_C2D41000
P 40B 980201F0_50000008
P 40C 5B020000_5B000000
P 40D 73420000_980201F8
P 40E 43800000_980201E8
P 40F 78000000_980201E0
S 1 100 FFFFFFFFFFFFFC98
S 2 108 0000000000002074
S 3 110 0000000000002175
